/* npu_core.f */
logic/npu_pkg.sv
logic/sync_fifo.sv
logic/elem_alu.sv
logic/write_back.sv
logic/npu_sequencer.sv
logic/npu_core.sv
tb/ddr_model.sv
tb/npu_core_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = npu_core_tb
FILELIST = npu_core.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tb/npu_core_tb.sv */
`timescale 1ns/100ps
// self-checking testbench that runs the instruction table on the matrix engine against the memory model
module npu_core_tb import npu_pkg::*; ();

	typedef struct packed {
		logic [3:0] op;
		dim_t m;
		dim_t n;
		addr_t src1;
		logic [31:0] src2_imm;
		addr_t dst;
	} test_t;

	localparam int NUM_TESTS = 9;

	// op, m, n, src1, src2 or immediate, dst
	test_t tests [NUM_TESTS] = '{
		'{4'd0, 9'd3, 9'd4, 32'h0000_0000, 32'h0000_0100, 32'h0000_0200},	// ADD
		'{4'd2, 9'd3, 9'd4, 32'h0000_0010, 32'h0000_0110, 32'h0000_0210},	// SUB
		'{4'd1, 9'd2, 9'd5, 32'h0000_0020, 32'hFFFE_8000, 32'h0000_0220},	// ADDi -1.5
		'{4'd3, 9'd2, 9'd3, 32'h0000_0030, 32'hFFFD_4000, 32'h0000_0230},	// SUBi -2.75
		'{4'd5, 9'd3, 9'd3, 32'h0000_0040, 32'hFFFF_2000, 32'h0000_0240},	// MULTi -0.875
		'{4'd6, 9'd3, 9'd4, 32'h0000_0050, 32'h0000_0150, 32'h0000_0250},	// DOT
		'{4'd10, 9'd4, 9'd4, 32'h0000_0060, 32'h0000_0000, 32'h0000_0260},	// RELU
		'{4'd7, 9'd2, 9'd2, 32'h0000_0070, 32'h0000_0170, 32'h0000_0270},	// unsupported
		'{4'd0, 9'd2, 9'd2, 32'h0000_0078, 32'h0000_0178, 32'h0000_0280}	// ADD again
	};

	logic clk;
	logic rst_n;
	npu_inst_t inst;
	logic inst_en;
	logic inst_ready;
	data_t inst_time;
	mem_rd_t rd;
	logic rd_ready;
	data_t rd_data;
	logic rd_data_valid;
	mem_wr_t wr;
	logic wr_ready;
	logic [31:0] lcg_state = 32'd52;

	npu_core #(.ROW_DEPTH_LOG2(9)) u_npu_core (
		.clk           (clk),
		.rst_n         (rst_n),
		.inst          (inst),
		.inst_en       (inst_en),
		.inst_ready    (inst_ready),
		.inst_time     (inst_time),
		.rd            (rd),
		.rd_ready      (rd_ready),
		.rd_data       (rd_data),
		.rd_data_valid (rd_data_valid),
		.wr            (wr),
		.wr_ready      (wr_ready)
	);

	ddr_model #(.SEED(52)) u_ddr_model (
		.clk           (clk),
		.rst_n         (rst_n),
		.rd            (rd),
		.rd_ready      (rd_ready),
		.rd_data       (rd_data),
		.rd_data_valid (rd_data_valid),
		.wr            (wr),
		.wr_ready      (wr_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// reference rules and helpers
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic data_t random_word();
		return data_t'($signed(lcg_next()) >>> 8);	// roughly +-128.0
	endfunction

	function automatic logic two_operand(input logic [3:0] op);
		return (op == 4'd0) || (op == 4'd2) || (op == 4'd6);
	endfunction

	function automatic logic supported_op(input logic [3:0] op);
		return two_operand(op) || (op == 4'd1) || (op == 4'd3) || (op == 4'd5) || (op == 4'd10);
	endfunction

	function automatic data_t expected_elem(input logic [3:0] op, input data_t a, input data_t b,
		input data_t imm);
		case (op)
			4'd0:    return a + b;
			4'd2:    return a - b;
			4'd1:    return a + imm;
			4'd3:    return a - imm;
			4'd5:    return fx_mul(a, imm);
			4'd6:    return fx_mul(a, b);
			4'd10:   return (a < 0) ? '0 : a;
			default: return a;
		endcase
	endfunction

	// generous per row to cover stalls and read latency
	function automatic int watchdog_cycles();
		int total;
		total = 100;
		foreach (tests[i])
			total += 12 * int'(tests[i].m) * int'(tests[i].n) + 20 * int'(tests[i].m) + 20;
		return total;
	endfunction

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic compare_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			fail_stop($sformatf("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic match_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			fail_stop($sformatf("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_stop($sformatf("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic count_equals(input string name, input int got, input int exp);
		if (got != exp)
			fail_stop($sformatf("Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// one table row through preload, prediction, issue, wait and checks
	task automatic run_test(input test_t t, input int idx);
		data_t exp_q[$];
		data_t a;
		data_t b;
		addr_t pa;
		addr_t pb;
		int elems;
		int rd_base;
		int wr_base;
		int exp_reads;
		int exp_writes;
		elems = int'(t.m) * int'(t.n);
		for (int i = 0; i < elems; i++)
		begin
			a = random_word();
			b = random_word();
			pa = t.src1 + addr_t'(i);
			pb = t.src2_imm + addr_t'(i);
			u_ddr_model.mem[pa[11:0]] = a;
			if (two_operand(t.op))
				u_ddr_model.mem[pb[11:0]] = b;
			exp_q.push_back(expected_elem(t.op, a, b, t.src2_imm));
		end
		exp_writes = supported_op(t.op) ? elems : 0;
		exp_reads = two_operand(t.op) ? 2 * elems : exp_writes;
		rd_base = u_ddr_model.rd_count;
		wr_base = u_ddr_model.wr_count;
		@(posedge clk);
		#1;
		inst = '{op: t.op, src1: t.src1, src2_imm: t.src2_imm, dst: t.dst, m: t.m, n: t.n,
			rsvd: '0};
		inst_en = 1'b1;
		@(posedge clk);	// accepted here, ready was high
		#1;
		inst_en = 1'b0;
		inst = '0;
		while (!inst_ready)
		begin
			@(posedge clk);
			#1;
		end
		count_equals($sformatf("reads of test %0d", idx), u_ddr_model.rd_count - rd_base,
			exp_reads);
		count_equals($sformatf("writes of test %0d", idx), u_ddr_model.wr_count - wr_base,
			exp_writes);
		for (int i = 0; i < exp_writes; i++)
		begin
			match_addr("wr.addr", u_ddr_model.wr_addr_log[wr_base + i], t.dst + addr_t'(i));
			compare_data("wr.data", u_ddr_model.wr_data_log[wr_base + i], exp_q[i]);
		end
		if (supported_op(t.op) && int'(inst_time) < elems)
			fail_stop($sformatf("inst_time of test %0d is only %0d cycles for %0d elements",
				idx, inst_time, elems));
	endtask

	initial
	begin
		rst_n = 1'b0;
		inst_en = 1'b0;
		inst = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_flag("inst_ready", inst_ready, 1'b1);
		check_flag("rd.req", rd.req, 1'b0);
		check_flag("wr.req", wr.req, 1'b0);
		foreach (tests[i])
			run_test(tests[i], i);
		$display("test passed");
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles()) @(posedge clk);
		fail_stop("watchdog timeout, the instruction table did not finish in time");
	end

endmodule

/* tb/ddr_model.sv */
`timescale 1ns/100ps
// word memory model for the testbench, random ready stalls, 3 cycle read latency and a write log
module ddr_model import npu_pkg::*; #(
	parameter int SEED = 52
) (
	input  logic    clk,
	input  logic    rst_n,
	input  mem_rd_t rd,
	output logic    rd_ready,
	output data_t   rd_data,
	output logic    rd_data_valid,
	input  mem_wr_t wr,
	output logic    wr_ready
);

	localparam int WORDS = 4096;

	data_t mem [WORDS];
	addr_t wr_addr_log [WORDS];	// every accepted write, in order
	data_t wr_data_log [WORDS];
	int rd_count = 0;
	int wr_count = 0;
	logic [31:0] lcg_state = 32'(SEED);
	logic rd_ready_q = 1'b0;
	logic wr_ready_q = 1'b0;
	logic valid_q = 1'b0;
	data_t data_q = '0;
	logic lat_v [2] = '{1'b0, 1'b0};	// read data in flight
	data_t lat_d [2];

	assign rd_ready = rd_ready_q;
	assign wr_ready = wr_ready_q;
	assign rd_data_valid = valid_q;
	assign rd_data = data_q;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	initial
	begin
		for (int i = 0; i < WORDS; i++)
			mem[i] = data_t'(i) ^ 32'h5A5A_0000;	// background pattern
	end

	//////////////////////////////////////////////////////////////////////
	// handshakes seen at the edge, new outputs a little after it
	always @(posedge clk)
	begin
		logic take;
		addr_t raddr;
		logic [31:0] r;
		take = rst_n && rd.req && rd_ready_q;
		raddr = rd.addr;
		if (take)
			rd_count++;
		if (rst_n && wr.req && wr_ready_q)
		begin
			mem[wr.addr[11:0]] = wr.data;
			wr_addr_log[wr_count] = wr.addr;
			wr_data_log[wr_count] = wr.data;
			wr_count++;
		end
		#1;
		valid_q = lat_v[1];
		data_q = lat_d[1];
		lat_v[1] = lat_v[0];
		lat_d[1] = lat_d[0];
		lat_v[0] = take;
		lat_d[0] = mem[raddr[11:0]];
		r = lcg_next();
		rd_ready_q = (r[17:16] != 2'b00);	// low about one cycle in four
		r = lcg_next();
		wr_ready_q = (r[17:16] != 2'b00);
	end

endmodule

/* logic/npu_core.sv */
`timescale 1ns/100ps
// matrix engine top level, connect the instruction port and one word memory port running on clk
module npu_core import npu_pkg::*; #(
	parameter int ROW_DEPTH_LOG2 = 9
) (
	input  logic      clk,
	input  logic      rst_n,
	input  npu_inst_t inst,
	input  logic      inst_en,
	output logic      inst_ready,
	output data_t     inst_time,
	output mem_rd_t   rd,
	input  logic      rd_ready,
	input  data_t     rd_data,
	input  logic      rd_data_valid,
	output mem_wr_t   wr,
	input  logic      wr_ready
);

	npu_cmd_t cmd;
	phase_t phase;
	logic start;
	logic row_done;
	logic [ROW_DEPTH_LOG2:0] row_count;	// words of $1 waiting
	logic buf_push;
	logic buf_pop;
	data_t buf_din;
	data_t buf_head;
	data_t result;
	logic result_valid;

	npu_sequencer #(.ROW_DEPTH_LOG2(ROW_DEPTH_LOG2)) u_npu_sequencer (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst       (inst),
		.inst_en    (inst_en),
		.inst_ready (inst_ready),
		.inst_time  (inst_time),
		.rd         (rd),
		.rd_ready   (rd_ready),
		.row_count  (row_count),
		.row_done   (row_done),
		.cmd        (cmd),
		.phase      (phase),
		.start      (start)
	);

	// holds one row of $1 for the two operand ops
	sync_fifo #(.ROW_DEPTH_LOG2(ROW_DEPTH_LOG2)) u_row_buf (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (buf_push),
		.din   (buf_din),
		.pop   (buf_pop),
		.dout  (buf_head),
		.count (row_count),
		.empty ()
	);

	elem_alu u_elem_alu (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd           (cmd),
		.phase         (phase),
		.rd_data       (rd_data),
		.rd_data_valid (rd_data_valid),
		.buf_push      (buf_push),
		.buf_din       (buf_din),
		.buf_pop       (buf_pop),
		.buf_head      (buf_head),
		.result        (result),
		.result_valid  (result_valid)
	);

	write_back #(.ROW_DEPTH_LOG2(ROW_DEPTH_LOG2)) u_write_back (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd          (cmd),
		.start        (start),
		.result       (result),
		.result_valid (result_valid),
		.wr           (wr),
		.wr_ready     (wr_ready),
		.row_done     (row_done)
	);

endmodule

/* logic/npu_sequencer.sv */
`timescale 1ns/100ps
// instruction control FSM, walks the rows of $1 and $2 and issues the memory reads
module npu_sequencer import npu_pkg::*; #(
	parameter int ROW_DEPTH_LOG2 = 9
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  npu_inst_t               inst,
	input  logic                    inst_en,
	output logic                    inst_ready,
	output data_t                   inst_time,
	output mem_rd_t                 rd,
	input  logic                    rd_ready,
	input  logic [ROW_DEPTH_LOG2:0] row_count,
	input  logic                    row_done,
	output npu_cmd_t                cmd,
	output phase_t                  phase,
	output logic                    start
);

	typedef enum logic [2:0] {IDLE, READ_A, WAIT_A, READ_B, DRAIN} state_t;
	typedef logic [ROW_DEPTH_LOG2:0] cnt_t;

	state_t state;
	dim_t m_r;
	dim_t row;	// current row
	dim_t col;	// reads issued in this row
	addr_t a_ptr;	// next $1 address
	addr_t b_ptr;	// next $2 address
	logic accept;
	logic last_col;

	assign accept = inst_en && inst_ready;
	assign last_col = (col == cmd.n - 1'b1);

	// addresses run on past each row, so row r starts at base + r*n
	assign rd = '{req: (state == READ_A || state == READ_B),
		addr: (state == READ_B) ? b_ptr : a_ptr};

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			cmd.op <= opcode_t'(inst.op);
			cmd.imm <= inst.src2_imm;
			cmd.dst <= inst.dst;
			cmd.n <= inst.n;
			m_r <= inst.m;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// row sequencing
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			inst_ready <= 1'b1;
			start <= 1'b0;
			phase <= PH_A;
			row <= '0;
			col <= '0;
		end
		else
		begin
			start <= accept;
			case (state)
				IDLE:
				begin
					if (accept)
					begin
						inst_ready <= 1'b0;
						row <= '0;
						col <= '0;
						phase <= PH_A;
						a_ptr <= inst.src1;
						b_ptr <= inst.src2_imm;
						// other opcodes stay here, ready again next cycle
						if (is_supported(inst.op) && inst.m != '0 && inst.n != '0)
							state <= READ_A;
					end
					else
						inst_ready <= 1'b1;
				end
				READ_A:
				begin
					if (rd_ready)
					begin
						a_ptr <= a_ptr + 1'b1;
						col <= last_col ? '0 : col + 1'b1;
						if (last_col && is_two_op(cmd.op))
							state <= WAIT_A;
						else if (last_col)
							state <= DRAIN;
					end
				end
				WAIT_A:
				begin
					if (row_count >= cnt_t'(cmd.n))	// whole $1 row buffered
					begin
						phase <= PH_B;
						state <= READ_B;
					end
				end
				READ_B:
				begin
					if (rd_ready)
					begin
						b_ptr <= b_ptr + 1'b1;
						col <= last_col ? '0 : col + 1'b1;
						if (last_col)
							state <= DRAIN;
					end
				end
				DRAIN:
				begin
					if (row_done)
					begin
						if (row == m_r - 1'b1)
						begin
							inst_ready <= 1'b1;
							state <= IDLE;
						end
						else
						begin
							row <= row + 1'b1;
							phase <= PH_A;
							state <= READ_A;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// execution time, cycles spent busy
	always_ff @(posedge clk)
	begin
		if (accept)
			inst_time <= '0;
		else if (!inst_ready)
			inst_time <= inst_time + 1'b1;
	end

endmodule

/* logic/write_back.sv */
`timescale 1ns/100ps
// result buffering and memory writes to consecutive addresses from dst, flags each finished row
module write_back import npu_pkg::*; #(
	parameter int ROW_DEPTH_LOG2 = 9
) (
	input  logic     clk,
	input  logic     rst_n,
	input  npu_cmd_t cmd,
	input  logic     start,
	input  data_t    result,
	input  logic     result_valid,
	output mem_wr_t  wr,
	input  logic     wr_ready,
	output logic     row_done
);

	addr_t wr_addr;
	dim_t col;	// column of the word at the FIFO head
	data_t head;
	logic empty;
	logic wr_ok;

	// one row deep, reads of the next row wait for row_done
	sync_fifo #(.ROW_DEPTH_LOG2(ROW_DEPTH_LOG2)) u_result_buf (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (result_valid),
		.din   (result),
		.pop   (wr_ok),
		.dout  (head),
		.count (),
		.empty (empty)
	);

	assign wr = '{req: !empty, addr: wr_addr, data: head};
	assign wr_ok = !empty && wr_ready;
	assign row_done = wr_ok && (col == cmd.n - 1'b1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			col <= '0;
		else if (start)
			col <= '0;
		else if (wr_ok)
			col <= row_done ? '0 : col + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (start)
			wr_addr <= cmd.dst;
		else if (wr_ok)
			wr_addr <= wr_addr + 1'b1;	// next word of $3
	end

endmodule

/* logic/elem_alu.sv */
`timescale 1ns/100ps
// element arithmetic, buffers $1 words or combines read data into one registered result
module elem_alu import npu_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  npu_cmd_t cmd,
	input  phase_t   phase,
	input  data_t    rd_data,
	input  logic     rd_data_valid,
	output logic     buf_push,
	output data_t    buf_din,
	output logic     buf_pop,
	input  data_t    buf_head,
	output data_t    result,
	output logic     result_valid
);

	logic two_op;
	data_t comb;

	assign two_op = is_two_op(cmd.op);
	assign buf_push = rd_data_valid && two_op && (phase == PH_A);
	assign buf_pop = rd_data_valid && two_op && (phase == PH_B);
	assign buf_din = rd_data;

	// $1 from the row buffer, $2 straight from memory
	always_comb
	begin
		case (cmd.op)
			OP_ADD:   comb = buf_head + rd_data;
			OP_SUB:   comb = buf_head - rd_data;
			OP_DOT:   comb = fx_mul(buf_head, rd_data);
			OP_ADDI:  comb = rd_data + cmd.imm;
			OP_SUBI:  comb = rd_data - cmd.imm;
			OP_MULTI: comb = fx_mul(rd_data, cmd.imm);
			OP_RELU:  comb = rd_data[DATA_WIDTH-1] ? '0 : rd_data;	// clamp negatives
			default:  comb = rd_data;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rd_data_valid)
			result <= comb;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			result_valid <= 1'b0;
		else
			result_valid <= rd_data_valid && !buf_push;	// no result while filling
	end

endmodule

/* logic/sync_fifo.sv */
`timescale 1ns/100ps
// single clock first-word-fall-through FIFO with fill count, 2**ROW_DEPTH_LOG2 words deep
module sync_fifo import npu_pkg::*; #(
	parameter int ROW_DEPTH_LOG2 = 9
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    push,
	input  data_t                   din,
	input  logic                    pop,
	output data_t                   dout,
	output logic [ROW_DEPTH_LOG2:0] count,
	output logic                    empty
);

	data_t mem [2**ROW_DEPTH_LOG2];
	logic [ROW_DEPTH_LOG2-1:0] wr_ptr;
	logic [ROW_DEPTH_LOG2-1:0] rd_ptr;

	assign dout = mem[rd_ptr];	// head visible without a pop
	assign empty = (count == '0);

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

endmodule

/* logic/npu_pkg.sv */
// shared widths, opcodes, instruction and memory port types for the matrix engine; import with npu_pkg::*
package npu_pkg;

	localparam int DATA_WIDTH = 32;	// word width
	localparam int FRAC_WIDTH = 16;	// binary point of Q16.16

	typedef logic signed [DATA_WIDTH-1:0] data_t;
	typedef logic [31:0] addr_t;	// word address
	typedef logic [8:0] dim_t;	// row or column count

	typedef enum logic [3:0]
	{
		OP_ADD   = 4'd0,
		OP_ADDI  = 4'd1,
		OP_SUB   = 4'd2,
		OP_SUBI  = 4'd3,
		OP_MULTI = 4'd5,
		OP_DOT   = 4'd6,
		OP_RELU  = 4'd10
	} opcode_t;

	typedef enum logic {PH_A, PH_B} phase_t;	// which operand the reads belong to

	//////////////////////////////////////////////////////////////////////
	// instruction word, MSB first
	typedef struct packed {
		logic [3:0] op;
		addr_t src1;
		logic [31:0] src2_imm;	// $2 address or immediate
		addr_t dst;
		dim_t m;
		dim_t n;
		logic [9:0] rsvd;
	} npu_inst_t;

	// latched instruction fields used while executing
	typedef struct packed {
		opcode_t op;
		data_t imm;
		addr_t dst;
		dim_t n;
	} npu_cmd_t;

	typedef struct packed {
		logic req;
		addr_t addr;
	} mem_rd_t;

	typedef struct packed {
		logic req;
		addr_t addr;
		data_t data;
	} mem_wr_t;

	//////////////////////////////////////////////////////////////////////
	// Q16.16 product, low fraction bits dropped
	function automatic data_t fx_mul(input data_t a, input data_t b);
		logic signed [2*DATA_WIDTH-1:0] prod;
		prod = a * b;
		return prod[DATA_WIDTH+FRAC_WIDTH-1:FRAC_WIDTH];
	endfunction

	function automatic logic is_supported(input logic [3:0] op);
		return op inside {OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MULTI, OP_DOT, OP_RELU};
	endfunction

	function automatic logic is_two_op(input logic [3:0] op);
		return op inside {OP_ADD, OP_SUB, OP_DOT};	// these also read $2
	endfunction

endpackage
